// ==== cdb_pkg.sv ====
// shared lane count, tag widths and tag types for the writeback path and its testbench
`default_nettype none

package cdb_pkg;

  // completion lanes on the bus
  // lanes 0 and 1 simple alu, 2 and 3 multiplier, 4 and 5 memory
  localparam int num_lanes = 6;

  // only the simple alu lanes carry exception and branch outcome
  localparam int num_alu_lanes = 2;

  // physical register file
  localparam int pr_width = 7;
  localparam int num_pr = 128;

  // architectural register file
  localparam int ar_width = 5;
  localparam int num_ar = 32;

  // resolved branch target
  localparam int addr_width = 64;

  // physical register tag
  typedef logic [pr_width-1:0] pr_tag_t;

  // architectural register tag
  typedef logic [ar_width-1:0] ar_tag_t;

  // branch target address
  typedef logic [addr_width-1:0] addr_t;

endpackage

`default_nettype wire

// ==== cdb_if.sv ====
// common data bus broadcast bundle, driven by cdb and read by the map and ready tables
`default_nettype none
`timescale 1ns/1ps

interface cdb_if
  import cdb_pkg::*;
();

  // one valid bit per lane, high for a single cycle
  logic [num_lanes-1:0] broadcast;

  // destination physical tag of each lane
  // meaningful only while the lane's broadcast bit is high
  pr_tag_t [num_lanes-1:0] pr_tag;

  // architectural register the lane writes
  ar_tag_t [num_lanes-1:0] ar_tag;

  // the bus register side
  modport bus_driver (
    output broadcast,
    output pr_tag,
    output ar_tag
  );

  // wakeup side, map table and ready table
  modport listener (
    input broadcast,
    input pr_tag,
    input ar_tag
  );

endinterface

`default_nettype wire

// ==== cdb.sv ====
// common data bus register stage, turns six completion strobes into one broadcast cycle
`default_nettype none
`timescale 1ns/1ps

module cdb
  import cdb_pkg::*;
(
  input  wire                              clock,
  input  wire                              reset,

  // completion lanes from the functional units
  input  wire  [num_lanes-1:0]             fu_complete,
  input  pr_tag_t [num_lanes-1:0]          fu_pr_idx,
  input  ar_tag_t [num_lanes-1:0]          fu_ar_idx,

  // simple alu outcome, lanes 0 and 1
  input  wire  [num_alu_lanes-1:0]         alu_exception,
  input  addr_t [num_alu_lanes-1:0]        alu_actual_addr,
  input  wire  [num_alu_lanes-1:0]         alu_actual_taken,

  // memory lane exceptions, taken in but not routed on yet
  input  wire  [num_alu_lanes-1:0]         mem_exception,

  // registered broadcast
  cdb_if.bus_driver                        bus,

  // toward the reorder buffer
  output logic [num_alu_lanes-1:0]         rob_exception,
  output addr_t [num_alu_lanes-1:0]        rob_actual_addr,
  output logic [num_alu_lanes-1:0]         rob_actual_taken
);

  // one cycle of latency on every lane
  // fully pipelined, a new set of strobes can land each cycle
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      bus.broadcast <= '0;
      bus.pr_tag    <= '0;
      bus.ar_tag    <= '0;
    end
    else
    begin
      // strobe and tags move together so a tag never outlives its valid
      bus.broadcast <= fu_complete;
      bus.pr_tag    <= fu_pr_idx;
      bus.ar_tag    <= fu_ar_idx;
    end
  end

  // branch resolution and exception flags ride alongside the broadcast
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      rob_exception    <= '0;
      rob_actual_addr  <= '0;
      rob_actual_taken <= '0;
    end
    else
    begin
      // only the simple alu lanes resolve branches
      rob_exception    <= alu_exception;
      rob_actual_addr  <= alu_actual_addr;
      rob_actual_taken <= alu_actual_taken;
    end
  end

  // mem_exception stops here
  // the rob has no exception slot for lanes 4 and 5 yet,
  // so a faulting load or store completes like any other lane

endmodule

`default_nettype wire

// ==== map_table.sv ====
// architectural to physical map with ready bits, written by rename and woken by the bus
`default_nettype none
`timescale 1ns/1ps

module map_table
  import cdb_pkg::*;
(
  input  wire                         clock,
  input  wire                         reset,

  // wakeup source
  cdb_if.listener                     bus,

  // rename write of a new mapping
  input  wire                         rename_valid,
  input  ar_tag_t                     rename_ar,
  input  pr_tag_t                     rename_pr,

  // two architectural lookups, read combinationally
  input  ar_tag_t [1:0]               lookup_ar,
  output pr_tag_t [1:0]               lookup_pr,
  output logic [1:0]                  lookup_ready
);

  // current physical tag of each architectural register
  pr_tag_t map_pr [num_ar];

  // set once the mapped physical register has been written back
  logic [num_ar-1:0] map_ready;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      // identity mapping, everything committed and ready
      for (int i = 0; i < num_ar; i++)
      begin
        map_pr[i]    <= pr_tag_t'(i);
        map_ready[i] <= 1'b1;
      end
    end
    else
    begin
      // wakeup for every active lane
      // a completion of an overwritten mapping no longer matches, so it is dropped
      for (int lane = 0; lane < num_lanes; lane++)
      begin
        if (bus.broadcast[lane] && map_pr[bus.ar_tag[lane]] == bus.pr_tag[lane])
        begin
          map_ready[bus.ar_tag[lane]] <= 1'b1;
        end
      end

      // rename comes last, so it overrides a same-cycle wakeup
      if (rename_valid)
      begin
        map_pr[rename_ar]    <= rename_pr;
        map_ready[rename_ar] <= 1'b0;
      end
    end
  end

  // lookups see stored state only, no bypass from the bus
  always_comb
  begin
    for (int port = 0; port < 2; port++)
    begin
      lookup_pr[port]    = map_pr[lookup_ar[port]];
      lookup_ready[port] = map_ready[lookup_ar[port]];
    end
  end

endmodule

`default_nettype wire

// ==== pr_ready_table.sv ====
// one ready bit per physical register, cleared on allocation and set by the bus
`default_nettype none
`timescale 1ns/1ps

module pr_ready_table
  import cdb_pkg::*;
(
  input  wire                    clock,
  input  wire                    reset,

  // wakeup source
  cdb_if.listener                bus,

  // allocation of a fresh destination register
  input  wire                    rename_valid,
  input  pr_tag_t                rename_pr,

  // source operand checks for the reservation stations
  input  pr_tag_t [1:0]          src_pr,
  output logic [1:0]             src_ready
);

  // bit per physical register
  logic [num_pr-1:0] pr_ready;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      // nothing in flight after reset
      pr_ready <= '1;
    end
    else
    begin
      // every broadcast tag becomes ready
      // stale or not, the value in that register is now written
      for (int lane = 0; lane < num_lanes; lane++)
      begin
        if (bus.broadcast[lane])
        begin
          pr_ready[bus.pr_tag[lane]] <= 1'b1;
        end
      end

      // allocation last, it wins over a same-cycle broadcast
      if (rename_valid)
      begin
        pr_ready[rename_pr] <= 1'b0;
      end
    end
  end

  // plain reads of the stored bits
  always_comb
  begin
    for (int port = 0; port < 2; port++)
    begin
      src_ready[port] = pr_ready[src_pr[port]];
    end
  end

endmodule

`default_nettype wire

// ==== writeback_top.sv ====
// writeback path top level, wires the bus register to the map table and the ready table
`default_nettype none
`timescale 1ns/1ps

module writeback_top
  import cdb_pkg::*;
(
  input  wire                              clock,
  input  wire                              reset,

  // completion lanes
  input  wire  [num_lanes-1:0]             fu_complete,
  input  pr_tag_t [num_lanes-1:0]          fu_pr_idx,
  input  ar_tag_t [num_lanes-1:0]          fu_ar_idx,

  // simple alu outcome
  input  wire  [num_alu_lanes-1:0]         alu_exception,
  input  addr_t [num_alu_lanes-1:0]        alu_actual_addr,
  input  wire  [num_alu_lanes-1:0]         alu_actual_taken,

  // memory lane exceptions
  input  wire  [num_alu_lanes-1:0]         mem_exception,

  // rename write
  input  wire                              rename_valid,
  input  ar_tag_t                          rename_ar,
  input  pr_tag_t                          rename_pr,

  // lookups
  input  pr_tag_t [1:0]                    src_pr,
  input  ar_tag_t [1:0]                    lookup_ar,

  // broadcast as seen by the rest of the core
  output logic [num_lanes-1:0]             cdb_broadcast,
  output pr_tag_t [num_lanes-1:0]          cdb_pr_tag,
  output ar_tag_t [num_lanes-1:0]          cdb_ar_tag,

  // reorder buffer fields
  output logic [num_alu_lanes-1:0]         rob_exception,
  output addr_t [num_alu_lanes-1:0]        rob_actual_addr,
  output logic [num_alu_lanes-1:0]         rob_actual_taken,

  // lookup results
  output pr_tag_t [1:0]                    lookup_pr,
  output logic [1:0]                       lookup_ready,
  output logic [1:0]                       src_ready
);

  cdb_if cdb_bus ();

  // broadcast also leaves the design for the rob and reservation stations
  assign cdb_broadcast = cdb_bus.broadcast;
  assign cdb_pr_tag    = cdb_bus.pr_tag;
  assign cdb_ar_tag    = cdb_bus.ar_tag;

  cdb cdb_inst (
    .clock            (clock),
    .reset            (reset),
    .fu_complete      (fu_complete),
    .fu_pr_idx        (fu_pr_idx),
    .fu_ar_idx        (fu_ar_idx),
    .alu_exception    (alu_exception),
    .alu_actual_addr  (alu_actual_addr),
    .alu_actual_taken (alu_actual_taken),
    .mem_exception    (mem_exception),
    .bus              (cdb_bus.bus_driver),
    .rob_exception    (rob_exception),
    .rob_actual_addr  (rob_actual_addr),
    .rob_actual_taken (rob_actual_taken)
  );

  // same rename write feeds both tables
  map_table map_table_inst (
    .clock        (clock),
    .reset        (reset),
    .bus          (cdb_bus.listener),
    .rename_valid (rename_valid),
    .rename_ar    (rename_ar),
    .rename_pr    (rename_pr),
    .lookup_ar    (lookup_ar),
    .lookup_pr    (lookup_pr),
    .lookup_ready (lookup_ready)
  );

  pr_ready_table pr_ready_table_inst (
    .clock        (clock),
    .reset        (reset),
    .bus          (cdb_bus.listener),
    .rename_valid (rename_valid),
    .rename_pr    (rename_pr),
    .src_pr       (src_pr),
    .src_ready    (src_ready)
  );

endmodule

`default_nettype wire

// ==== writeback_props.sv ====
// concurrent checks on bus latency and reset state, bound into writeback_top
`default_nettype none
`timescale 1ns/1ps

module writeback_props
  import cdb_pkg::*;
(
  input wire                        clock,
  input wire                        reset,
  input wire  [num_lanes-1:0]       fu_complete,
  input pr_tag_t [num_lanes-1:0]    fu_pr_idx,
  input ar_tag_t [num_lanes-1:0]    fu_ar_idx,
  input wire  [num_alu_lanes-1:0]   alu_exception,
  input addr_t [num_alu_lanes-1:0]  alu_actual_addr,
  input wire  [num_alu_lanes-1:0]   alu_actual_taken,
  input wire  [num_lanes-1:0]       cdb_broadcast,
  input pr_tag_t [num_lanes-1:0]    cdb_pr_tag,
  input ar_tag_t [num_lanes-1:0]    cdb_ar_tag,
  input wire  [num_alu_lanes-1:0]   rob_exception,
  input addr_t [num_alu_lanes-1:0]  rob_actual_addr,
  input wire  [num_alu_lanes-1:0]   rob_actual_taken
);

  // strobes and tags appear exactly one edge later
  bus_latency: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) |-> (cdb_broadcast == $past(fu_complete)) &&
      (cdb_pr_tag == $past(fu_pr_idx)) && (cdb_ar_tag == $past(fu_ar_idx)))
    else $error("bus outputs do not follow the completion lanes by one cycle");

  // rob fields come from the alu lanes only, memory faults never show up
  rob_latency: assert property (@(posedge clock) disable iff (reset)
    !$past(reset) |-> (rob_exception == $past(alu_exception)) &&
      (rob_actual_taken == $past(alu_actual_taken)) &&
      (rob_actual_addr == $past(alu_actual_addr)))
    else $error("rob fields do not follow the alu lanes by one cycle");

  // a reset edge leaves the bus empty
  reset_clear: assert property (@(posedge clock)
    $past(reset) |-> (cdb_broadcast == '0) && (cdb_pr_tag == '0) && (cdb_ar_tag == '0) &&
      (rob_exception == '0) && (rob_actual_taken == '0) && (rob_actual_addr == '0))
    else $error("bus or rob fields not zero after reset");

endmodule

bind writeback_top writeback_props writeback_props_inst (.*);

`default_nettype wire

// ==== tb_writeback.sv ====
// self-checking testbench for writeback_top, run it as the simulation top with project.f
`default_nettype none
`timescale 1ns/1ps

module tb_writeback
  import cdb_pkg::*;
();

  localparam int clk_period = 4;
  // reset, lookup sweep, directed cases, random bursts and drain
  localparam int test_cycles = 470;

  logic clock;
  logic reset;
  logic [num_lanes-1:0] fu_complete;
  pr_tag_t [num_lanes-1:0] fu_pr_idx;
  ar_tag_t [num_lanes-1:0] fu_ar_idx;
  logic [num_alu_lanes-1:0] alu_exception;
  addr_t [num_alu_lanes-1:0] alu_actual_addr;
  logic [num_alu_lanes-1:0] alu_actual_taken;
  logic [num_alu_lanes-1:0] mem_exception;
  logic rename_valid;
  ar_tag_t rename_ar;
  pr_tag_t rename_pr;
  pr_tag_t [1:0] src_pr;
  ar_tag_t [1:0] lookup_ar;
  logic [num_lanes-1:0] cdb_broadcast;
  pr_tag_t [num_lanes-1:0] cdb_pr_tag;
  ar_tag_t [num_lanes-1:0] cdb_ar_tag;
  logic [num_alu_lanes-1:0] rob_exception;
  addr_t [num_alu_lanes-1:0] rob_actual_addr;
  logic [num_alu_lanes-1:0] rob_actual_taken;
  pr_tag_t [1:0] lookup_pr;
  logic [1:0] lookup_ready;
  logic [1:0] src_ready;

  // expected bus contents, one cycle behind the strobes
  logic [num_lanes-1:0] exp_bc;
  pr_tag_t [num_lanes-1:0] exp_pr;
  ar_tag_t [num_lanes-1:0] exp_ar;
  // expected map and ready tables
  pr_tag_t m_pr [num_ar];
  logic [num_ar-1:0] m_rdy;
  logic [num_pr-1:0] p_rdy;
  int errors;
  int seed;

  writeback_top writeback_top_inst (.*);

  initial
  begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  // reference model, advances on the same edge as the DUT
  always @(posedge clock)
  begin
    if (reset)
    begin
      for (int i = 0; i < num_ar; i++)
      begin
        m_pr[i] = pr_tag_t'(i);
      end
      m_rdy = '1;
      p_rdy = '1;
      exp_bc = '0;
    end
    else
    begin
      // wakeup from last cycle's broadcast, map only if the tag is still live
      for (int l = 0; l < num_lanes; l++)
      begin
        if (exp_bc[l])
        begin
          p_rdy[exp_pr[l]] = 1'b1;
          if (m_pr[exp_ar[l]] == exp_pr[l])
          begin
            m_rdy[exp_ar[l]] = 1'b1;
          end
        end
      end
      // allocation beats a same-cycle wakeup
      if (rename_valid)
      begin
        m_pr[rename_ar] = rename_pr;
        m_rdy[rename_ar] = 1'b0;
        p_rdy[rename_pr] = 1'b0;
      end
      exp_bc = fu_complete;
      exp_pr = fu_pr_idx;
      exp_ar = fu_ar_idx;
    end
  end

  task automatic compare(input string name, input logic [127:0] got, input logic [127:0] want);
    assert (got === want)
    else
    begin
      errors++;
      $display("mismatch at %0d ns: %s got %0h expected %0h", $time, name, got, want);
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clock)
  begin
    if (!reset)
    begin
      for (int p = 0; p < 2; p++)
      begin
        compare($sformatf("lookup_pr[%0d]", p), 128'(lookup_pr[p]), 128'(m_pr[lookup_ar[p]]));
        compare($sformatf("lookup_ready[%0d]", p), 128'(lookup_ready[p]),
          128'(m_rdy[lookup_ar[p]]));
        compare($sformatf("src_ready[%0d]", p), 128'(src_ready[p]), 128'(p_rdy[src_pr[p]]));
      end
    end
  end

  task automatic tick();
    @(posedge clock);
    #1;
  endtask

  // one-cycle rename write
  task automatic allocate(input ar_tag_t ar, input pr_tag_t pr);
    rename_valid = 1'b1;
    rename_ar = ar;
    rename_pr = pr;
    tick();
    rename_valid = 1'b0;
  endtask

  // one-cycle completion strobe on a single lane
  task automatic complete(input int lane, input pr_tag_t pr, input ar_tag_t ar);
    fu_complete[lane] = 1'b1;
    fu_pr_idx[lane] = pr;
    fu_ar_idx[lane] = ar;
    tick();
    fu_complete = '0;
  endtask

  // random lanes, mostly live tags so wakeups land
  task automatic random_burst();
    logic [31:0] r;
    logic [31:0] r2;
    for (int l = 0; l < num_lanes; l++)
    begin
      r = $random(seed);
      fu_complete[l] = r[0];
      fu_ar_idx[l] = r[12:8];
      fu_pr_idx[l] = (r[3:1] != 3'd0) ? m_pr[r[12:8]] : r[22:16];
    end
    r = $random(seed);
    rename_valid = r[0];
    rename_ar = r[5:1];
    rename_pr = r[12:6];
    alu_exception = r[14:13];
    alu_actual_taken = r[16:15];
    // memory faults must stay off rob_exception
    mem_exception = r[18:17];
    lookup_ar[0] = r[23:19];
    lookup_ar[1] = fu_ar_idx[0];
    src_pr[0] = r[30:24];
    src_pr[1] = fu_pr_idx[1];
    for (int a = 0; a < num_alu_lanes; a++)
    begin
      r = $random(seed);
      r2 = $random(seed);
      alu_actual_addr[a] = {r, r2};
    end
  endtask

  initial
  begin
    seed = 32'h64b3;
    errors = 0;
    reset = 1'b1;
    // lanes busy through reset, the bus and rob fields must still come out zero
    fu_complete = '1;
    fu_pr_idx = '1;
    fu_ar_idx = '1;
    alu_exception = '1;
    alu_actual_addr = '1;
    alu_actual_taken = '1;
    mem_exception = '1;
    rename_valid = 1'b0;
    rename_ar = '0;
    rename_pr = '0;
    src_pr = '0;
    lookup_ar = '0;
    repeat (10) @(posedge clock);
    #1;
    reset = 1'b0;
    fu_complete = '0;
    fu_pr_idx = '0;
    fu_ar_idx = '0;
    alu_exception = '0;
    alu_actual_addr = '0;
    alu_actual_taken = '0;
    mem_exception = '0;

    // identity map, everything ready
    for (int i = 0; i < num_pr; i++)
    begin
      lookup_ar[0] = i[4:0];
      lookup_ar[1] = ~i[4:0];
      src_pr[0] = i[6:0];
      src_pr[1] = ~i[6:0];
      tick();
    end

    // rename clears ready, matching completion sets it back
    lookup_ar = {5'd7, 5'd5};
    src_pr = {7'd110, 7'd100};
    allocate(5'd5, 7'd100);
    tick();
    complete(2, 7'd100, 5'd5);
    tick();
    tick();

    // old tag 100 finishes after r5 moved on to 101
    allocate(5'd5, 7'd100);
    allocate(5'd5, 7'd101);
    complete(4, 7'd100, 5'd5);
    tick();
    tick();

    // r7 renamed again while its wakeup sits on the bus
    allocate(5'd7, 7'd110);
    complete(0, 7'd110, 5'd7);
    allocate(5'd7, 7'd111);
    tick();

    repeat (300)
    begin
      random_burst();
      tick();
    end
    fu_complete = '0;
    rename_valid = 1'b0;
    mem_exception = '0;
    repeat (3) tick();

    $display("checks done, errors: %0d", errors);
    if (errors == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  // watchdog
  initial
  begin
    #(clk_period * (test_cycles + 100));
    $display("watchdog expired before the test sequence finished");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
cdb_pkg.sv
cdb_if.sv
cdb.sv
map_table.sv
pr_ready_table.sv
writeback_top.sv
writeback_props.sv
tb_writeback.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the writeback testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_writeback -f project.f -o sim_writeback
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_writeback > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$log"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1
